//--- filelist.f
verilog/dmac_pkg.sv
verilog/ctrl_demux.sv
verilog/chan_prog.sv
verilog/cmd_arbiter.sv
verilog/dma_engine.sv
verilog/dmac_wrap.sv
sim/dmac_assert.sv
sim/tb_dmac.sv

//--- run_sim.sh
#!/bin/sh
# build and run the DMA testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module tb_dmac -f filelist.f

# the pass line decides the result
out=$(./obj_dir/Vtb_dmac 2>&1 || true)
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

//--- sim/tb_dmac.sv
/*
 * testbench of the two-channel DMA block
 * models TCDM and external memory with random stalls, programs both
 * channels over the control port and checks the copied words
 */

`timescale 1ns/1ps
`default_nettype none

module tb_dmac;

   import dmac_pkg::*;

   localparam int   timeout_cycles = 2000;
   localparam logic ch_load        = 1'(chan_load);
   localparam logic ch_store       = 1'(chan_store);

   logic               clk_i;
   logic               arst_n_i;
   mem_req_t           ctrl_req;
   mem_rsp_t           ctrl_rsp;
   mem_req_t           tcdm_req;
   mem_rsp_t           tcdm_rsp;
   mem_req_t           ext_req;
   mem_rsp_t           ext_rsp;
   logic [nb_chan-1:0] term_event;
   logic               busy;

   // memory models as word arrays indexed by byte address bits 11:2
   logic [31:0] tcdm_mem [0:1023];
   logic [31:0] ext_mem  [0:1023];
   logic        tcdm_ready, ext_ready;
   logic        tcdm_rvalid, ext_rvalid;
   logic [31:0] tcdm_rdata, ext_rdata;
   logic [31:0] seed;

   // term event bookkeeping
   int   term_cnt [nb_chan];
   logic ev_q [$];

   assign tcdm_rsp = {tcdm_req.req & tcdm_ready, tcdm_rvalid, tcdm_rdata};
   assign ext_rsp  = {ext_req.req & ext_ready, ext_rvalid, ext_rdata};

   dmac_wrap u_dmac_wrap
   (
      .clk_i        ( clk_i      ),
      .arst_n_i     ( arst_n_i   ),
      .ctrl_req_i   ( ctrl_req   ),
      .ctrl_rsp_o   ( ctrl_rsp   ),
      .tcdm_req_o   ( tcdm_req   ),
      .tcdm_rsp_i   ( tcdm_rsp   ),
      .ext_req_o    ( ext_req    ),
      .ext_rsp_i    ( ext_rsp    ),
      .term_event_o ( term_event ),
      .busy_o       ( busy       )
   );

   //************************************************************
   // helpers
   //************************************************************
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // fill value depends on the full byte address
   function automatic logic [31:0] addr_pattern(input logic [31:0] a);
      return a ^ {a[15:0], a[31:16]} ^ 32'h3c5a_0f96;
   endfunction

   // bank interleave moves bits 11:9 to 6:4 and bits 8:4 up to 11:7
   function automatic logic [31:0] tcdm_phys_addr(input logic [31:0] lin);
      logic [31:0] row;
      logic [31:0] bank;
      row  = (lin >> 4) & 32'h1f;
      bank = (lin >> 9) & 32'h7;
      return (lin & 32'hffff_f00f) | (row << 7) | (bank << 4);
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic expect_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
      assert (act == exp)
      else
         abort_run($sformatf("** Error %s: expected %h, actual %h", name, exp, act));
   endtask

   // one control access that starts and ends 10 ns after a rising edge
   task automatic bus_access(input logic wr, input logic ch, input logic [3:0] off,
                             input logic [31:0] wdata, output logic [31:0] rdata,
                             output int waited);
      int n;
      ctrl_req.req   = 1'b1;
      ctrl_req.add   = (32'(ch) << chan_sel_bit) | 32'(off);
      ctrl_req.wen   = ~wr;
      ctrl_req.be    = '1;
      ctrl_req.wdata = wdata;
      waited = 0;
      @(negedge clk_i);
      while (!ctrl_rsp.gnt)
      begin
         waited++;
         if (waited > timeout_cycles)
            abort_run("timeout waiting for control grant");
         @(negedge clk_i);
      end
      @(posedge clk_i);
      #10;
      ctrl_req = '0;
      // response due in the cycle after the grant
      n = 0;
      @(negedge clk_i);
      while (!ctrl_rsp.r_valid)
      begin
         n++;
         if (n > timeout_cycles)
            abort_run("timeout waiting for control response");
         @(negedge clk_i);
      end
      rdata = ctrl_rsp.r_rdata;
      @(posedge clk_i);
      #10;
   endtask

   task automatic set_addresses(input logic ch, input logic [31:0] tcdm_a,
                                input logic [31:0] ext_a);
      logic [31:0] rd;
      int          waited;
      bus_access(1'b1, ch, reg_tcdm_add, tcdm_a, rd, waited);
      bus_access(1'b1, ch, reg_ext_add, ext_a, rd, waited);
   endtask

   task automatic issue_cmd(input logic ch, input logic [15:0] len, output int waited);
      logic [31:0] rd;
      bus_access(1'b1, ch, reg_cmd, {16'h0, len}, rd, waited);
   endtask

   task automatic check_reg(input string name, input logic ch, input logic [3:0] off,
                            input logic [31:0] exp);
      logic [31:0] rd;
      int          waited;
      bus_access(1'b0, ch, off, 32'h0, rd, waited);
      expect_word(name, exp, rd);
   endtask

   task automatic clear_events();
      term_cnt[0] = 0;
      term_cnt[1] = 0;
      ev_q.delete();
   endtask

   task automatic wait_term_events(input logic ch, input int target);
      int n;
      n = 0;
      while (term_cnt[ch] < target)
      begin
         n++;
         if (n > timeout_cycles)
            abort_run($sformatf("timeout waiting for term event of channel %0d", ch));
         @(posedge clk_i);
         #10;
      end
   endtask

   // ext words must sit at the remapped TCDM address
   task automatic check_load_copy(input string name, input logic [31:0] tcdm_base,
                                  input logic [31:0] ext_base, input int words);
      logic [31:0] phys;
      logic [31:0] ext_a;
      for (int w = 0; w < words; w++)
      begin
         ext_a = ext_base + 32'(w * 4);
         phys  = tcdm_phys_addr(tcdm_base + 32'(w * 4));
         expect_word($sformatf("%s word %0d", name, w), addr_pattern(ext_a),
                     tcdm_mem[phys[11:2]]);
      end
   endtask

   // TCDM words from remapped addresses land at linear ext addresses
   task automatic check_store_copy(input string name, input logic [31:0] tcdm_base,
                                   input logic [31:0] ext_base, input int words);
      logic [31:0] phys;
      logic [31:0] ext_a;
      for (int w = 0; w < words; w++)
      begin
         ext_a = ext_base + 32'(w * 4);
         phys  = tcdm_phys_addr(tcdm_base + 32'(w * 4));
         expect_word($sformatf("%s word %0d", name, w), addr_pattern(phys),
                     ext_mem[ext_a[11:2]]);
      end
   endtask

   //************************************************************
   // clock, stalls, memories, event monitor
   //************************************************************
   initial
   begin : clock_gen
      clk_i = 1'b0;
      forever
         #50 clk_i = ~clk_i;
   end

   initial
   begin : stall_gen
      seed       = 32'hea29;
      tcdm_ready = 1'b0;
      ext_ready  = 1'b0;
      forever
      begin
         @(posedge clk_i);
         #10;
         seed       = lcg_next(seed);
         // ready about three cycles in four
         tcdm_ready = (seed[17:16] != 2'b00);
         ext_ready  = (seed[25:24] != 2'b00);
      end
   end

   initial
   begin : tcdm_model
      logic        hit;
      logic        rd;
      logic [9:0]  idx;
      logic [31:0] wd;
      logic [3:0]  wbe;
      tcdm_rvalid = 1'b0;
      tcdm_rdata  = '0;
      forever
      begin
         // request sampled mid cycle and served after the edge
         @(negedge clk_i);
         hit = tcdm_req.req && tcdm_ready;
         rd  = tcdm_req.wen;
         idx = tcdm_req.add[11:2];
         wd  = tcdm_req.wdata;
         wbe = tcdm_req.be;
         @(posedge clk_i);
         #10;
         tcdm_rvalid = hit && rd;
         if (hit && rd)
            tcdm_rdata = tcdm_mem[idx];
         if (hit && !rd)
         begin
            // only enabled bytes change
            for (int b = 0; b < 4; b++)
            begin
               if (wbe[b])
                  tcdm_mem[idx][b*8 +: 8] = wd[b*8 +: 8];
            end
         end
      end
   end

   initial
   begin : ext_model
      logic        hit;
      logic        rd;
      logic [9:0]  idx;
      logic [31:0] wd;
      logic [3:0]  wbe;
      ext_rvalid = 1'b0;
      ext_rdata  = '0;
      forever
      begin
         @(negedge clk_i);
         hit = ext_req.req && ext_ready;
         rd  = ext_req.wen;
         idx = ext_req.add[11:2];
         wd  = ext_req.wdata;
         wbe = ext_req.be;
         @(posedge clk_i);
         #10;
         ext_rvalid = hit && rd;
         if (hit && rd)
            ext_rdata = ext_mem[idx];
         if (hit && !rd)
         begin
            for (int b = 0; b < 4; b++)
            begin
               if (wbe[b])
                  ext_mem[idx][b*8 +: 8] = wd[b*8 +: 8];
            end
         end
      end
   end

   initial
   begin : term_monitor
      forever
      begin
         @(negedge clk_i);
         for (int c = 0; c < nb_chan; c++)
         begin
            if (term_event[c[0]])
            begin
               term_cnt[c[0]] = term_cnt[c[0]] + 1;
               ev_q.push_back(c[0]);
            end
         end
      end
   end

   //************************************************************
   // stimulus
   //************************************************************
   initial
   begin : stimulus
      int waited;
      arst_n_i = 1'b0;
      ctrl_req = '0;
      clear_events();
      for (int i = 0; i < 1024; i++)
      begin
         tcdm_mem[i[9:0]] = addr_pattern(32'(i) << 2);
         ext_mem[i[9:0]]  = addr_pattern(32'h1c00_0000 | (32'(i) << 2));
      end
      repeat (4)
         @(posedge clk_i);
      #10;
      arst_n_i = 1'b1;

      // register readback
      set_addresses(ch_load, 32'h0000_0e00, 32'h1c00_0000);
      set_addresses(ch_store, 32'h0000_0a40, 32'h1c00_0400);
      check_reg("readback load tcdm_add", ch_load, reg_tcdm_add, 32'h0000_0e00);
      check_reg("readback load ext_add", ch_load, reg_ext_add, 32'h1c00_0000);
      check_reg("readback store tcdm_add", ch_store, reg_tcdm_add, 32'h0000_0a40);
      check_reg("readback store ext_add", ch_store, reg_ext_add, 32'h1c00_0400);
      check_reg("readback load status", ch_load, reg_status, 32'h0);
      check_reg("readback store status", ch_store, reg_status, 32'h0);

      // single load followed by a single store
      issue_cmd(ch_load, 16'd8, waited);
      wait_term_events(ch_load, 1);
      check_load_copy("load", 32'h0000_0e00, 32'h1c00_0000, 8);
      issue_cmd(ch_store, 16'd8, waited);
      wait_term_events(ch_store, 1);
      check_store_copy("store", 32'h0000_0a40, 32'h1c00_0400, 8);

      // back to back with the load first
      clear_events();
      set_addresses(ch_load, 32'h0000_0200, 32'h1c00_0100);
      set_addresses(ch_store, 32'h0000_0c80, 32'h1c00_0500);
      issue_cmd(ch_load, 16'd8, waited);
      issue_cmd(ch_store, 16'd8, waited);
      wait_term_events(ch_load, 1);
      wait_term_events(ch_store, 1);
      expect_word("back to back load events", 32'd1, term_cnt[0]);
      expect_word("back to back store events", 32'd1, term_cnt[1]);
      expect_word("back to back event count", 32'd2, ev_q.size());
      expect_word("back to back first event", 32'(ch_load), 32'(ev_q[0]));
      check_load_copy("back to back load", 32'h0000_0200, 32'h1c00_0100, 8);
      check_store_copy("back to back store", 32'h0000_0c80, 32'h1c00_0500, 8);

      // second store command must wait for the slot to free up
      clear_events();
      set_addresses(ch_load, 32'h0000_0600, 32'h1c00_0800);
      set_addresses(ch_store, 32'h0000_0400, 32'h1c00_0c00);
      issue_cmd(ch_load, 16'd8, waited);
      issue_cmd(ch_store, 16'd8, waited);
      issue_cmd(ch_store, 16'd8, waited);
      expect_word("second store cmd stalled", 32'd1, 32'(waited > 0));
      expect_word("busy during transfers", 32'd1, 32'(busy));
      wait_term_events(ch_load, 1);
      wait_term_events(ch_store, 2);
      // low from the cycle of the last event on
      expect_word("busy after last event", 32'd0, 32'(busy));
      check_load_copy("stall load", 32'h0000_0600, 32'h1c00_0800, 8);
      check_store_copy("stall store", 32'h0000_0400, 32'h1c00_0c00, 8);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- sim/dmac_assert.sv
/*
 * protocol assertions on the DMA top-level ports
 * bound into dmac_wrap, reports through $error only
 */

`timescale 1ns/1ps
`default_nettype none

module dmac_assert
(
   input logic                         clk_i,
   input logic                         arst_n_i,
   input dmac_pkg::mem_req_t           ctrl_req_i,
   input dmac_pkg::mem_rsp_t           ctrl_rsp_o,
   input dmac_pkg::mem_req_t           tcdm_req_o,
   input dmac_pkg::mem_rsp_t           tcdm_rsp_i,
   input dmac_pkg::mem_req_t           ext_req_o,
   input dmac_pkg::mem_rsp_t           ext_rsp_i,
   input logic [dmac_pkg::nb_chan-1:0] term_event_o,
   input logic                         busy_o
);

   import dmac_pkg::*;

   //************************************************************
   // control port
   //************************************************************
   ctrl_rvalid_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ctrl_req_i.req && ctrl_rsp_o.gnt |=> ctrl_rsp_o.r_valid)
      else $error("control r_valid missing after a grant");

   // and never without one
   ctrl_rvalid_only_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ctrl_rsp_o.r_valid |-> $past(ctrl_req_i.req && ctrl_rsp_o.gnt))
      else $error("control r_valid without a granted access");

   // one-cycle end of transfer pulses
   for (genvar c = 0; c < nb_chan; c++)
   begin : g_term
      term_pulse_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
         term_event_o[c] |=> !term_event_o[c])
         else $error("term event %0d high for more than one cycle", c);
   end

   //************************************************************
   // memory ports
   //************************************************************
   tcdm_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      tcdm_req_o.req && !tcdm_rsp_i.gnt |=> $stable(tcdm_req_o))
      else $error("TCDM request changed before its grant");

   ext_stable_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      ext_req_o.req && !ext_rsp_i.gnt |=> $stable(ext_req_o))
      else $error("external request changed before its grant");

   // idle block leaves both ports quiet
   idle_quiet_a: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !busy_o |-> !tcdm_req_o.req && !ext_req_o.req)
      else $error("memory request while busy is low");

endmodule

bind dmac_wrap dmac_assert u_dmac_assert
(
   .clk_i        ( clk_i        ),
   .arst_n_i     ( arst_n_i     ),
   .ctrl_req_i   ( ctrl_req_i   ),
   .ctrl_rsp_o   ( ctrl_rsp_o   ),
   .tcdm_req_o   ( tcdm_req_o   ),
   .tcdm_rsp_i   ( tcdm_rsp_i   ),
   .ext_req_o    ( ext_req_o    ),
   .ext_rsp_i    ( ext_rsp_i    ),
   .term_event_o ( term_event_o ),
   .busy_o       ( busy_o       )
);

`default_nettype wire

//--- verilog/dmac_wrap.sv
/*
 * top level of the two-channel DMA block
 * control port in front, one TCDM port and one external port behind
 * load and store channels share the engine through the arbiter
 */

`timescale 1ns/1ps
`default_nettype none

module dmac_wrap
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,

   input  dmac_pkg::mem_req_t           ctrl_req_i,
   output dmac_pkg::mem_rsp_t           ctrl_rsp_o,

   output dmac_pkg::mem_req_t           tcdm_req_o,
   input  dmac_pkg::mem_rsp_t           tcdm_rsp_i,

   output dmac_pkg::mem_req_t           ext_req_o,
   input  dmac_pkg::mem_rsp_t           ext_rsp_i,

   output logic [dmac_pkg::nb_chan-1:0] term_event_o,
   output logic                         busy_o
);

   import dmac_pkg::*;

   // front end to channels
   reg_acc_t                             acc;
   logic [nb_chan-1:0]                   chan_req;
   logic [nb_chan-1:0]                   chan_accept;
   logic [nb_chan-1:0][data_width-1:0]   chan_rdata;

   // channels to arbiter
   logic [nb_chan-1:0]                   xfer_req;
   dma_xfer_t [nb_chan-1:0]              chan_xfer;
   logic [nb_chan-1:0]                   chan_grant;

   // arbiter to engine
   logic                                 xfer_valid;
   dma_xfer_t                            xfer;
   logic                                 engine_idle;

   //************************************************************
   // control front end
   //************************************************************
   ctrl_demux u_ctrl_demux
   (
      .clk_i         ( clk_i       ),
      .arst_n_i      ( arst_n_i    ),
      .ctrl_req_i    ( ctrl_req_i  ),
      .ctrl_rsp_o    ( ctrl_rsp_o  ),
      .acc_o         ( acc         ),
      .chan_req_o    ( chan_req    ),
      .chan_accept_i ( chan_accept ),
      .chan_rdata_i  ( chan_rdata  )
   );

   // ext to TCDM
   chan_prog #(.chan(chan_load)) u_load
   (
      .clk_i      ( clk_i                   ),
      .arst_n_i   ( arst_n_i                ),
      .req_i      ( chan_req[chan_load]     ),
      .acc_i      ( acc                     ),
      .accept_o   ( chan_accept[chan_load]  ),
      .rdata_o    ( chan_rdata[chan_load]   ),
      .xfer_req_o ( xfer_req[chan_load]     ),
      .xfer_o     ( chan_xfer[chan_load]    ),
      .grant_i    ( chan_grant[chan_load]   )
   );

   // TCDM to ext
   chan_prog #(.chan(chan_store)) u_store
   (
      .clk_i      ( clk_i                   ),
      .arst_n_i   ( arst_n_i                ),
      .req_i      ( chan_req[chan_store]    ),
      .acc_i      ( acc                     ),
      .accept_o   ( chan_accept[chan_store] ),
      .rdata_o    ( chan_rdata[chan_store]  ),
      .xfer_req_o ( xfer_req[chan_store]    ),
      .xfer_o     ( chan_xfer[chan_store]   ),
      .grant_i    ( chan_grant[chan_store]  )
   );

   //************************************************************
   // shared engine
   //************************************************************
   cmd_arbiter u_cmd_arbiter
   (
      .clk_i         ( clk_i       ),
      .arst_n_i      ( arst_n_i    ),
      .chan_req_i    ( xfer_req    ),
      .chan_xfer_i   ( chan_xfer   ),
      .chan_grant_o  ( chan_grant  ),
      .engine_idle_i ( engine_idle ),
      .xfer_valid_o  ( xfer_valid  ),
      .xfer_o        ( xfer        )
   );

   dma_engine u_dma_engine
   (
      .clk_i        ( clk_i        ),
      .arst_n_i     ( arst_n_i     ),
      .xfer_valid_i ( xfer_valid   ),
      .xfer_i       ( xfer         ),
      .idle_o       ( engine_idle  ),
      .tcdm_req_o   ( tcdm_req_o   ),
      .tcdm_rsp_i   ( tcdm_rsp_i   ),
      .ext_req_o    ( ext_req_o    ),
      .ext_rsp_i    ( ext_rsp_i    ),
      .term_event_o ( term_event_o ),
      .busy_o       ( busy_o       )
   );

endmodule

`default_nettype wire

//--- verilog/dma_engine.sv
/*
 * shared copy engine, one 32-bit word at a time
 * reads the source port, then writes the destination port
 * TCDM addresses go out bank-interleave remapped
 */

`timescale 1ns/1ps
`default_nettype none

module dma_engine
(
   input  logic                         clk_i,
   input  logic                         arst_n_i,
   input  logic                         xfer_valid_i,
   input  dmac_pkg::dma_xfer_t          xfer_i,
   output logic                         idle_o,
   output dmac_pkg::mem_req_t           tcdm_req_o,
   input  dmac_pkg::mem_rsp_t           tcdm_rsp_i,
   output dmac_pkg::mem_req_t           ext_req_o,
   input  dmac_pkg::mem_rsp_t           ext_rsp_i,
   output logic [dmac_pkg::nb_chan-1:0] term_event_o,
   output logic                         busy_o
);

   import dmac_pkg::*;

   typedef enum logic [1:0] {st_idle, st_read, st_rwait, st_write} state_t;

   state_t                state_q;
   logic                  dir_q;
   logic                  chan_q;
   logic [len_width-1:0]  cnt_q;
   logic [addr_width-1:0] tcdm_add_q;
   logic [addr_width-1:0] ext_add_q;
   logic [data_width-1:0] data_q;
   logic [nb_chan-1:0]    term_q;
   mem_rsp_t              src_rsp;
   mem_rsp_t              dst_rsp;
   logic                  wr_done;
   logic                  last_wr;

   // top row bits of the SRAM part drop to just above bit 3
   function automatic logic [addr_width-1:0] tcdm_remap(input logic [addr_width-1:0] a);
      return {a[addr_width-1:sram_add_width],
              a[sram_add_width-remap_bank_bits-1:remap_low_bits],
              a[sram_add_width-1:sram_add_width-remap_bank_bits],
              a[remap_low_bits-1:0]};
   endfunction

   // dir high reads TCDM and writes ext
   assign src_rsp = dir_q ? tcdm_rsp_i : ext_rsp_i;
   assign dst_rsp = dir_q ? ext_rsp_i : tcdm_rsp_i;

   assign wr_done = (state_q == st_write) && dst_rsp.gnt;
   assign last_wr = wr_done && (cnt_q == len_width'(1));

   //************************************************************
   // FSM
   //************************************************************
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         state_q <= st_idle;
         dir_q   <= 1'b0;
         chan_q  <= 1'b0;
         cnt_q   <= '0;
         term_q  <= '0;
      end
      else
      begin
         // one pulse, on the channel that finished
         term_q <= '0;
         if (last_wr)
            term_q[chan_q] <= 1'b1;
         case (state_q)
            st_idle:
            begin
               if (xfer_valid_i)
               begin
                  state_q <= st_read;
                  dir_q   <= xfer_i.dir;
                  chan_q  <= xfer_i.chan;
                  cnt_q   <= xfer_i.len;
               end
            end
            st_read:
            begin
               if (src_rsp.gnt)
                  state_q <= st_rwait;
            end
            st_rwait:
            begin
               if (src_rsp.r_valid)
                  state_q <= st_write;
            end
            default:
            begin
               if (wr_done)
               begin
                  cnt_q   <= cnt_q - len_width'(1);
                  state_q <= last_wr ? st_idle : st_read;
               end
            end
         endcase
      end
   end

   // addresses and the word in flight
   always_ff @(posedge clk_i)
   begin
      if (state_q == st_idle && xfer_valid_i)
      begin
         tcdm_add_q <= xfer_i.tcdm_add;
         ext_add_q  <= xfer_i.ext_add;
      end
      else if (wr_done)
      begin
         tcdm_add_q <= tcdm_add_q + addr_width'(4);
         ext_add_q  <= ext_add_q + addr_width'(4);
      end
      if (state_q == st_rwait && src_rsp.r_valid)
         data_q <= src_rsp.r_rdata;
   end

   //************************************************************
   // memory ports
   //************************************************************
   always_comb
   begin
      tcdm_req_o       = '0;
      ext_req_o        = '0;
      tcdm_req_o.add   = tcdm_remap(tcdm_add_q);
      tcdm_req_o.wen   = (state_q == st_read);
      tcdm_req_o.be    = '1;
      tcdm_req_o.wdata = data_q;
      ext_req_o.add    = ext_add_q;
      ext_req_o.wen    = (state_q == st_read);
      ext_req_o.be     = '1;
      ext_req_o.wdata  = data_q;
      // read on the source, write on the destination
      tcdm_req_o.req   = (state_q == st_read && dir_q) || (state_q == st_write && !dir_q);
      ext_req_o.req    = (state_q == st_read && !dir_q) || (state_q == st_write && dir_q);
   end

   assign idle_o       = (state_q == st_idle);
   assign term_event_o = term_q;
   // pending work shows up as xfer_valid while idle
   assign busy_o       = !idle_o || xfer_valid_i;

endmodule

`default_nettype wire

//--- verilog/cmd_arbiter.sv
/*
 * round-robin arbiter between the two channels
 * grants the idle engine to one pending channel per transfer
 * and forwards that channel's descriptor
 */

`timescale 1ns/1ps
`default_nettype none

module cmd_arbiter
(
   input  logic                                         clk_i,
   input  logic                                         arst_n_i,
   input  logic [dmac_pkg::nb_chan-1:0]                 chan_req_i,
   input  dmac_pkg::dma_xfer_t [dmac_pkg::nb_chan-1:0]  chan_xfer_i,
   output logic [dmac_pkg::nb_chan-1:0]                 chan_grant_o,
   input  logic                                         engine_idle_i,
   output logic                                         xfer_valid_o,
   output dmac_pkg::dma_xfer_t                          xfer_o
);

   import dmac_pkg::*;

   logic last_q;
   logic win;

   // both pending: the one not served last time
   always_comb
   begin
      if (chan_req_i[chan_load] && chan_req_i[chan_store])
         win = ~last_q;
      else
         win = chan_req_i[chan_store];
   end

   // grant only while the engine sits idle
   assign xfer_valid_o = engine_idle_i & (|chan_req_i);
   assign xfer_o       = chan_xfer_i[win];

   always_comb
   begin
      chan_grant_o      = '0;
      chan_grant_o[win] = xfer_valid_o;
   end

   // starts as if store went last, load wins first
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         last_q <= 1'(chan_store);
      else if (xfer_valid_o)
         last_q <= win;
   end

endmodule

`default_nettype wire

//--- verilog/chan_prog.sv
/*
 * register set of one DMA channel
 * holds the two addresses, the length and one pending command
 * instantiated once per channel, chan gives its index
 */

`timescale 1ns/1ps
`default_nettype none

module chan_prog
#(
   parameter int chan = dmac_pkg::chan_load
)
(
   input  logic                            clk_i,
   input  logic                            arst_n_i,
   input  logic                            req_i,
   input  dmac_pkg::reg_acc_t              acc_i,
   output logic                            accept_o,
   output logic [dmac_pkg::data_width-1:0] rdata_o,
   output logic                            xfer_req_o,
   output dmac_pkg::dma_xfer_t             xfer_o,
   input  logic                            grant_i
);

   import dmac_pkg::*;

   ctrl_word_u            wword;
   logic [3:0]            reg_off;
   logic                  is_cmd;
   logic                  wr_en;
   logic [addr_width-1:0] tcdm_add_q;
   logic [addr_width-1:0] ext_add_q;
   logic [len_width-1:0]  len_q;
   logic                  pending_q;

   assign wword.add = acc_i.wdata;
   assign reg_off   = {acc_i.offset, 2'b00};
   assign is_cmd    = acc_i.wr && (reg_off == reg_cmd);

   // one command slot, a second cmd write waits for the grant
   assign accept_o = ~(is_cmd & pending_q);
   assign wr_en    = req_i & acc_i.wr & accept_o;

   //************************************************************
   // registers
   //************************************************************
   always_ff @(posedge clk_i)
   begin
      if (wr_en && reg_off == reg_tcdm_add)
         tcdm_add_q <= wword.add;
      if (wr_en && reg_off == reg_ext_add)
         ext_add_q <= wword.add;
      // zero length means one word
      if (wr_en && is_cmd)
         len_q <= (wword.cmd.len == '0) ? len_width'(1) : wword.cmd.len;
   end

   // set by cmd write, cleared when the engine takes it
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         pending_q <= 1'b0;
      else if (grant_i)
         pending_q <= 1'b0;
      else if (wr_en && is_cmd)
         pending_q <= 1'b1;
   end

   // readback, sampled by the front end at the grant edge
   always_comb
   begin
      case (reg_off)
         reg_tcdm_add: rdata_o = tcdm_add_q;
         reg_ext_add:  rdata_o = ext_add_q;
         reg_cmd:      rdata_o = data_width'(len_q);
         reg_status:   rdata_o = data_width'(pending_q);
         default:      rdata_o = '0;
      endcase
   end

   //************************************************************
   // descriptor towards the arbiter
   //************************************************************
   assign xfer_req_o      = pending_q;
   assign xfer_o.dir      = (chan == chan_store);
   assign xfer_o.tcdm_add = tcdm_add_q;
   assign xfer_o.ext_add  = ext_add_q;
   assign xfer_o.len      = len_q;
   assign xfer_o.chan     = 1'(chan);

endmodule

`default_nettype wire

//--- verilog/ctrl_demux.sv
/*
 * control bus front end
 * steers each core access to the load or store channel register set
 * and returns the read data one cycle after the grant
 */

`timescale 1ns/1ps
`default_nettype none

module ctrl_demux
(
   input  logic                                             clk_i,
   input  logic                                             arst_n_i,
   input  dmac_pkg::mem_req_t                               ctrl_req_i,
   output dmac_pkg::mem_rsp_t                               ctrl_rsp_o,
   output dmac_pkg::reg_acc_t                               acc_o,
   output logic [dmac_pkg::nb_chan-1:0]                     chan_req_o,
   input  logic [dmac_pkg::nb_chan-1:0]                     chan_accept_i,
   input  logic [dmac_pkg::nb_chan-1:0][dmac_pkg::data_width-1:0] chan_rdata_i
);

   import dmac_pkg::*;

   logic                  sel;
   logic                  gnt;
   logic                  r_valid_q;
   logic [data_width-1:0] rdata_q;

   // channel index straight from the address
   assign sel = ctrl_req_i.add[chan_sel_bit];

   // same access goes to both, only one sees req
   assign acc_o.wr     = ~ctrl_req_i.wen;
   assign acc_o.offset = ctrl_req_i.add[3:2];
   assign acc_o.wdata  = ctrl_req_i.wdata;

   always_comb
   begin
      chan_req_o      = '0;
      chan_req_o[sel] = ctrl_req_i.req;
   end

   // channel may hold off a cmd write
   assign gnt = ctrl_req_i.req & chan_accept_i[sel];

   //************************************************************
   // response path
   //************************************************************
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         r_valid_q <= 1'b0;
      else
         r_valid_q <= gnt;
   end

   // sampled at the grant edge
   always_ff @(posedge clk_i)
   begin
      if (gnt)
         rdata_q <= chan_rdata_i[sel];
   end

   assign ctrl_rsp_o.gnt     = gnt;
   assign ctrl_rsp_o.r_valid = r_valid_q;
   assign ctrl_rsp_o.r_rdata = rdata_q;

endmodule

`default_nettype wire

//--- verilog/dmac_pkg.sv
/*
 * shared definitions of the two-channel DMA block
 * bus widths, register map, TCDM remap fields and the bus structs
 * modules pull it in with a wildcard import in the module body
 */

`default_nettype none

package dmac_pkg;

   //************************************************************
   // widths
   //************************************************************
   localparam int data_width     = 32;
   localparam int addr_width     = 32;
   localparam int be_width       = data_width / 8;
   localparam int len_width      = 16;

   // TCDM byte address, SRAM part excludes the SCM bit
   localparam int tcdm_add_width = 13;
   localparam int sram_add_width = tcdm_add_width - 1;

   // bank interleave remap fields
   localparam int remap_bank_bits = 3;
   localparam int remap_low_bits  = 4;

   // channels
   localparam int nb_chan    = 2;
   localparam int chan_load  = 0;
   localparam int chan_store = 1;

   //************************************************************
   // control register map
   //************************************************************
   // address bit that picks load or store
   localparam int chan_sel_bit = 4;

   localparam logic [3:0] reg_tcdm_add = 4'h0;
   localparam logic [3:0] reg_ext_add  = 4'h4;
   localparam logic [3:0] reg_cmd      = 4'h8;
   // bit 0 is the pending flag
   localparam logic [3:0] reg_status   = 4'hC;

   // request side of a req/gnt/r_valid bus, wen high is a read
   typedef struct packed {
      logic                  req;
      logic [addr_width-1:0] add;
      logic                  wen;
      logic [be_width-1:0]   be;
      logic [data_width-1:0] wdata;
   } mem_req_t;

   // response side of the same bus
   typedef struct packed {
      logic                  gnt;
      logic                  r_valid;
      logic [data_width-1:0] r_rdata;
   } mem_rsp_t;

   // command word, len 0 counts as one word
   typedef struct packed {
      logic [data_width-len_width-1:0] rsvd;
      logic [len_width-1:0]            len;
   } dma_cmd_t;

   // written word, seen as an address or as a command
   typedef union packed {
      logic [data_width-1:0] add;
      dma_cmd_t              cmd;
   } ctrl_word_u;

   // register access from the front end to one channel
   typedef struct packed {
      logic                  wr;
      logic [1:0]            offset;
      logic [data_width-1:0] wdata;
   } reg_acc_t;

   // transfer descriptor, dir high moves TCDM to external
   typedef struct packed {
      logic                  dir;
      logic [addr_width-1:0] tcdm_add;
      logic [addr_width-1:0] ext_add;
      logic [len_width-1:0]  len;
      logic                  chan;
   } dma_xfer_t;

endpackage

`default_nettype wire
